// ==== common/glbl_map_pkg.sv ====
// Global register map definitions
`default_nettype none

package glbl_map_pkg;

   // Word address inside the 32-entry map
   typedef logic [4:0] reg_addr_t;

   // ----------------------------------------
   // Register addresses
   // ----------------------------------------
   localparam reg_addr_t ADDR_CHIP_ID   = 5'd0;
   localparam reg_addr_t ADDR_RST_CTRL  = 5'd1;
   localparam reg_addr_t ADDR_CORE_CFG  = 5'd2;
   localparam reg_addr_t ADDR_INTR_MASK = 5'd3;
   localparam reg_addr_t ADDR_INTR_STAT = 5'd4;
   localparam reg_addr_t ADDR_MFUNC_SEL = 5'd5;
   localparam reg_addr_t ADDR_RANDOM    = 5'd9;
   localparam reg_addr_t ADDR_MAILBOX   = 5'd15;
   localparam reg_addr_t ADDR_SW0       = 5'd16;
   localparam reg_addr_t ADDR_SW1       = 5'd17;
   localparam reg_addr_t ADDR_SW2       = 5'd18;
   localparam reg_addr_t ADDR_SW3       = 5'd19;

   // ----------------------------------------
   // Constants and reset values
   // ----------------------------------------
   // Manufacturer 8268, one core, chip 5, revision 01
   localparam logic [31:0] CHIP_ID_WORD       = 32'h8268_1501;
   // Core 0, interface and flash out of reset
   localparam logic [31:0] RST_CTRL_BOOT_RUN  = 32'h0000_0103;
   // Core 0 held, interface and flash released
   localparam logic [31:0] RST_CTRL_BOOT_HOLD = 32'h0000_0003;
   // UART master and debug tap enabled at power up
   localparam logic [31:0] MFUNC_RESET        = 32'hC000_0000;
   // ASCII signature, release code, project revision
   localparam logic [31:0] SW0_RESET          = 32'h8273_8343;
   localparam logic [31:0] SW1_RESET          = 32'h0001_0100;
   localparam logic [31:0] SW2_RESET          = 32'h0005_2000;
   // Random generator start state and feedback mask
   localparam logic [31:0] LFSR_SEED          = 32'hACE1_2468;
   localparam logic [31:0] LFSR_TAPS          = 32'h8020_0003;

endpackage

`default_nettype wire

// ==== common/glbl_intr_pkg.sv ====
// Interrupt source layout
`default_nettype none

package glbl_intr_pkg;

   // Status, mask and line width
   localparam int INTR_W        = 32;
   // usb, i2c master, rtc, ir
   localparam int ASYNC_INTR_W  = 4;
   localparam int TIMER_W       = 3;
   localparam int GPIO_INTR_LSB = 8;

   // Bit order inside async_intr
   localparam int ASYNC_USB  = 0;
   localparam int ASYNC_I2CM = 1;
   localparam int ASYNC_RTC  = 2;
   localparam int ASYNC_IR   = 3;

   // ----------------------------------------
   // Positions in the status word
   // ----------------------------------------
   localparam int TIMER_LSB = 0;
   localparam int I2CM_BIT  = 3;
   localparam int USB_BIT   = 4;
   localparam int PWM_BIT   = 5;
   localparam int RTC_BIT   = 6;
   localparam int IR_BIT    = 7;

   // Flops in each request synchronizer
   localparam int SYNC_STAGES_DEF = 2;

endpackage

`default_nettype wire

// ==== hw/lfsr_random.sv ====
// Pseudorandom word generator
`timescale 1ns/1ps
`default_nettype none

module lfsr_random (
   input  logic        mclk,
   input  logic        s_reset_n,
   input  logic        acc_done,
   output logic [31:0] random_word
);

   logic [31:0] lfsr_q;
   logic [31:0] lfsr_nxt;

   // ----------------------------------------
   // Galois step, right shift
   // ----------------------------------------
   always_comb begin
      lfsr_nxt = {1'b0, lfsr_q[31:1]};
      // Bit shifted out folds the taps back in
      if (lfsr_q[0]) begin
         lfsr_nxt = lfsr_nxt ^ glbl_map_pkg::LFSR_TAPS;
      end
   end

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         lfsr_q <= glbl_map_pkg::LFSR_SEED;
      end else if (acc_done) begin
         lfsr_q <= lfsr_nxt;
      end
   end

   // Read returns the state before the step
   assign random_word = lfsr_q;

   // All-zero state would lock the generator
   lfsr_not_zero: assert property (
      @(posedge mclk) disable iff (!s_reset_n) lfsr_q != '0
   );

endmodule

`default_nettype wire

// ==== intr/intr_ctrl.sv ====
// Interrupt status controller
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                                   mclk,
   input  logic                                   s_reset_n,
   // Requests
   input  logic [glbl_intr_pkg::ASYNC_INTR_W-1:0] async_intr,
   input  logic [glbl_intr_pkg::TIMER_W-1:0]      timer_intr,
   input  logic                                   pwm_intr,
   input  logic [glbl_intr_pkg::INTR_W-1:0]       gpio_intr,
   // Software side
   input  logic                                   stat_clr_en,
   input  logic [glbl_intr_pkg::INTR_W-1:0]       stat_clr_data,
   input  logic [glbl_intr_pkg::INTR_W-1:0]       intr_mask,
   output logic [glbl_intr_pkg::INTR_W-1:0]       intr_stat,
   output logic [glbl_intr_pkg::INTR_W-1:0]       irq_lines
);

   logic [SYNC_STAGES-1:0][glbl_intr_pkg::ASYNC_INTR_W-1:0] sync_q;
   logic [glbl_intr_pkg::ASYNC_INTR_W-1:0]                  async_sync;
   logic [glbl_intr_pkg::INTR_W-1:0]                        hw_req;
   logic [glbl_intr_pkg::INTR_W-1:0]                        clr_mask;

   // ----------------------------------------
   // Request synchronizers
   // ----------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= async_intr;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Last stage feeds the status
   assign async_sync = sync_q[SYNC_STAGES-1];

   // Request vector by package positions
   always_comb begin
      hw_req = '0;
      hw_req[glbl_intr_pkg::TIMER_LSB +: glbl_intr_pkg::TIMER_W] = timer_intr;
      hw_req[glbl_intr_pkg::I2CM_BIT] = async_sync[glbl_intr_pkg::ASYNC_I2CM];
      hw_req[glbl_intr_pkg::USB_BIT]  = async_sync[glbl_intr_pkg::ASYNC_USB];
      hw_req[glbl_intr_pkg::PWM_BIT]  = pwm_intr;
      hw_req[glbl_intr_pkg::RTC_BIT]  = async_sync[glbl_intr_pkg::ASYNC_RTC];
      hw_req[glbl_intr_pkg::IR_BIT]   = async_sync[glbl_intr_pkg::ASYNC_IR];
      // Low gpio bits have no status slot
      hw_req[glbl_intr_pkg::INTR_W-1:glbl_intr_pkg::GPIO_INTR_LSB] =
         gpio_intr[glbl_intr_pkg::INTR_W-1:glbl_intr_pkg::GPIO_INTR_LSB];
   end

   // ----------------------------------------
   // Sticky status
   // ----------------------------------------
   assign clr_mask = stat_clr_en ? stat_clr_data : '0;

   // Set wins over a clear in the same cycle
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_stat <= '0;
      end else begin
         intr_stat <= (intr_stat & ~clr_mask) | hw_req;
      end
   end

   assign irq_lines = intr_mask & intr_stat;

   // A line only fires from a latched status bit
   irq_from_stat: assert property (
      @(posedge mclk) disable iff (!s_reset_n) (irq_lines & ~intr_stat) == '0
   );

endmodule

`default_nettype wire

// ==== regs/glbl_reg_file.sv ====
// Global register file
`timescale 1ns/1ps
`default_nettype none

module glbl_reg_file (
   input  logic                             mclk,
   input  logic                             s_reset_n,
   input  logic                             strap_boot_run,
   // Register bus
   input  logic                             reg_cs,
   input  logic                             reg_wr,
   input  glbl_map_pkg::reg_addr_t          reg_addr,
   input  logic [31:0]                      reg_wdata,
   input  logic [3:0]                       reg_be,
   output logic [31:0]                      reg_rdata,
   output logic                             reg_ack,
   // Read-only sources
   input  logic [glbl_intr_pkg::INTR_W-1:0] intr_stat,
   input  logic [31:0]                      random_word,
   // Side controls
   output logic                             acc_done,
   output logic                             stat_clr_en,
   output logic [glbl_intr_pkg::INTR_W-1:0] stat_clr_data,
   output logic [glbl_intr_pkg::INTR_W-1:0] intr_mask,
   output logic                             soft_irq,
   output logic [2:0]                       user_irq,
   output logic [15:0]                      cfg_riscv_ctrl,
   output logic [31:0]                      cfg_multi_func_sel,
   // Block resets
   output logic                             cpu_intf_rst_n,
   output logic                             qspim_rst_n,
   output logic                             sspim_rst_n,
   output logic [1:0]                       uart_rst_n,
   output logic                             i2cm_rst_n,
   output logic                             usb_rst_n,
   output logic [3:0]                       cpu_core_rst_n
);

   logic        acc_start;
   logic        wr_en;
   logic [31:0] be_mask;
   logic [31:0] reg_out;
   logic [31:0] rst_ctrl;
   logic [31:0] core_cfg;
   logic [31:0] mfunc_sel;
   logic [31:0] mailbox;
   logic [31:0] sw0;
   logic [31:0] sw1;
   logic [31:0] sw2;
   logic [31:0] sw3;

   // Keep old bytes where the enable is low
   function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                            input logic [31:0] new_val,
                                            input logic [31:0] mask);
      be_merge = (old_val & ~mask) | (new_val & mask);
   endfunction

   // ----------------------------------------
   // Bus handshake
   // ----------------------------------------
   // New access when select is seen without a pending ack
   assign acc_start = reg_cs & ~reg_ack;
   assign wr_en     = acc_start & reg_wr;
   assign be_mask   = {{8{reg_be[3]}}, {8{reg_be[2]}}, {8{reg_be[1]}}, {8{reg_be[0]}}};

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack   <= 1'b0;
         reg_rdata <= '0;
      end else if (acc_start) begin
         reg_ack   <= 1'b1;
         reg_rdata <= reg_out;
      end else begin
         reg_ack   <= 1'b0;
      end
   end

   // Generator steps at the end of the ack cycle
   assign acc_done = reg_ack;

   // W1C lands in the ack cycle, bus still held by master
   assign stat_clr_en   = reg_ack & reg_cs & reg_wr &
                          (reg_addr == glbl_map_pkg::ADDR_INTR_STAT);
   assign stat_clr_data = reg_wdata & be_mask;

   // ----------------------------------------
   // Writable words
   // ----------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         // Boot strap picks core 0 run or hold
         rst_ctrl  <= strap_boot_run ? glbl_map_pkg::RST_CTRL_BOOT_RUN
                                     : glbl_map_pkg::RST_CTRL_BOOT_HOLD;
         core_cfg  <= '0;
         intr_mask <= '0;
         mfunc_sel <= glbl_map_pkg::MFUNC_RESET;
         mailbox   <= '0;
         sw0       <= glbl_map_pkg::SW0_RESET;
         sw1       <= glbl_map_pkg::SW1_RESET;
         sw2       <= glbl_map_pkg::SW2_RESET;
         sw3       <= '0;
      end else if (wr_en) begin
         case (reg_addr)
            glbl_map_pkg::ADDR_RST_CTRL:  rst_ctrl  <= be_merge(rst_ctrl, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_CORE_CFG:  core_cfg  <= be_merge(core_cfg, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_INTR_MASK: intr_mask <= be_merge(intr_mask, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_MFUNC_SEL: mfunc_sel <= be_merge(mfunc_sel, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_MAILBOX:   mailbox   <= be_merge(mailbox, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_SW0:       sw0       <= be_merge(sw0, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_SW1:       sw1       <= be_merge(sw1, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_SW2:       sw2       <= be_merge(sw2, reg_wdata, be_mask);
            glbl_map_pkg::ADDR_SW3:       sw3       <= be_merge(sw3, reg_wdata, be_mask);
            // Read-only and unmapped words ignore writes
            default: ;
         endcase
      end
   end

   // Core configuration fields
   assign soft_irq           = core_cfg[3];
   assign user_irq           = core_cfg[2:0];
   assign cfg_riscv_ctrl     = core_cfg[31:16];
   assign cfg_multi_func_sel = mfunc_sel;

   // ----------------------------------------
   // Reset outputs from reset control
   // ----------------------------------------
   assign cpu_intf_rst_n = rst_ctrl[0];
   assign qspim_rst_n    = rst_ctrl[1];
   assign sspim_rst_n    = rst_ctrl[2];
   assign uart_rst_n     = {rst_ctrl[6], rst_ctrl[3]};
   assign i2cm_rst_n     = rst_ctrl[4];
   assign usb_rst_n      = rst_ctrl[5];
   assign cpu_core_rst_n = rst_ctrl[11:8];

   // Read-back mux, holes read as zero
   always_comb begin
      case (reg_addr)
         glbl_map_pkg::ADDR_CHIP_ID:   reg_out = glbl_map_pkg::CHIP_ID_WORD;
         glbl_map_pkg::ADDR_RST_CTRL:  reg_out = rst_ctrl;
         glbl_map_pkg::ADDR_CORE_CFG:  reg_out = core_cfg;
         glbl_map_pkg::ADDR_INTR_MASK: reg_out = intr_mask;
         glbl_map_pkg::ADDR_INTR_STAT: reg_out = intr_stat;
         glbl_map_pkg::ADDR_MFUNC_SEL: reg_out = mfunc_sel;
         glbl_map_pkg::ADDR_RANDOM:    reg_out = random_word;
         glbl_map_pkg::ADDR_MAILBOX:   reg_out = mailbox;
         glbl_map_pkg::ADDR_SW0:       reg_out = sw0;
         glbl_map_pkg::ADDR_SW1:       reg_out = sw1;
         glbl_map_pkg::ADDR_SW2:       reg_out = sw2;
         glbl_map_pkg::ADDR_SW3:       reg_out = sw3;
         default:                      reg_out = '0;
      endcase
   end

   // Ack is a single-cycle pulse
   ack_single_cycle: assert property (
      @(posedge mclk) disable iff (!s_reset_n) reg_ack |=> !reg_ack
   );

endmodule

`default_nettype wire

// ==== hw/glbl_reg_top.sv ====
// Global register block top
`timescale 1ns/1ps
`default_nettype none

module glbl_reg_top #(
   parameter int SYNC_STAGES = glbl_intr_pkg::SYNC_STAGES_DEF
) (
   input  logic                                   mclk,
   input  logic                                   s_reset_n,
   input  logic                                   strap_boot_run,
   // Register bus
   input  logic                                   reg_cs,
   input  logic                                   reg_wr,
   input  glbl_map_pkg::reg_addr_t                reg_addr,
   input  logic [31:0]                            reg_wdata,
   input  logic [3:0]                             reg_be,
   output logic [31:0]                            reg_rdata,
   output logic                                   reg_ack,
   // Interrupt requests
   input  logic [glbl_intr_pkg::ASYNC_INTR_W-1:0] async_intr,
   input  logic [glbl_intr_pkg::TIMER_W-1:0]      timer_intr,
   input  logic                                   pwm_intr,
   input  logic [glbl_intr_pkg::INTR_W-1:0]       gpio_intr,
   // Core side
   output logic [glbl_intr_pkg::INTR_W-1:0]       irq_lines,
   output logic                                   soft_irq,
   output logic [2:0]                             user_irq,
   output logic [15:0]                            cfg_riscv_ctrl,
   output logic [31:0]                            cfg_multi_func_sel,
   // Block resets
   output logic                                   cpu_intf_rst_n,
   output logic                                   qspim_rst_n,
   output logic                                   sspim_rst_n,
   output logic [1:0]                             uart_rst_n,
   output logic                                   i2cm_rst_n,
   output logic                                   usb_rst_n,
   output logic [3:0]                             cpu_core_rst_n
);

   logic                             acc_done;
   logic                             stat_clr_en;
   logic [glbl_intr_pkg::INTR_W-1:0] stat_clr_data;
   logic [glbl_intr_pkg::INTR_W-1:0] intr_mask;
   logic [glbl_intr_pkg::INTR_W-1:0] intr_stat;
   logic [31:0]                      random_word;

   // Bus decode and register storage
   glbl_reg_file u_reg_file (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .strap_boot_run     (strap_boot_run),
      .reg_cs             (reg_cs),
      .reg_wr             (reg_wr),
      .reg_addr           (reg_addr),
      .reg_wdata          (reg_wdata),
      .reg_be             (reg_be),
      .intr_stat          (intr_stat),
      .random_word        (random_word),
      .reg_rdata          (reg_rdata),
      .reg_ack            (reg_ack),
      .acc_done           (acc_done),
      .stat_clr_en        (stat_clr_en),
      .stat_clr_data      (stat_clr_data),
      .intr_mask          (intr_mask),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel),
      .cpu_intf_rst_n     (cpu_intf_rst_n),
      .qspim_rst_n        (qspim_rst_n),
      .sspim_rst_n        (sspim_rst_n),
      .uart_rst_n         (uart_rst_n),
      .i2cm_rst_n         (i2cm_rst_n),
      .usb_rst_n          (usb_rst_n),
      .cpu_core_rst_n     (cpu_core_rst_n)
   );

   // Sticky status and masked lines
   intr_ctrl #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_intr_ctrl (
      .mclk          (mclk),
      .s_reset_n     (s_reset_n),
      .async_intr    (async_intr),
      .timer_intr    (timer_intr),
      .pwm_intr      (pwm_intr),
      .gpio_intr     (gpio_intr),
      .stat_clr_en   (stat_clr_en),
      .stat_clr_data (stat_clr_data),
      .intr_mask     (intr_mask),
      .intr_stat     (intr_stat),
      .irq_lines     (irq_lines)
   );

   // Random word, one step per access
   lfsr_random u_random (
      .mclk        (mclk),
      .s_reset_n   (s_reset_n),
      .acc_done    (acc_done),
      .random_word (random_word)
   );

endmodule

`default_nettype wire

// ==== tests/glbl_reg_model.svh ====
// Register map reference model
`ifndef GLBL_REG_MODEL_SVH
`define GLBL_REG_MODEL_SVH

// ----------------------------------------
// Model state
// ----------------------------------------
logic [31:0] shadow [0:31];
logic [31:0] stat_model;
logic [31:0] lfsr_model;

// Reset image with the strap choosing core 0 run or hold
function automatic void model_reset(input logic boot_run);
   for (int i = 0; i < 32; i++) begin
      shadow[i] = 32'h0;
   end
   shadow[0]  = glbl_map_pkg::CHIP_ID_WORD;
   shadow[1]  = boot_run ? glbl_map_pkg::RST_CTRL_BOOT_RUN : glbl_map_pkg::RST_CTRL_BOOT_HOLD;
   shadow[5]  = glbl_map_pkg::MFUNC_RESET;
   shadow[16] = glbl_map_pkg::SW0_RESET;
   shadow[17] = glbl_map_pkg::SW1_RESET;
   shadow[18] = glbl_map_pkg::SW2_RESET;
   stat_model = 32'h0;
   lfsr_model = glbl_map_pkg::LFSR_SEED;
endfunction

// Right shift with taps folded in when a one drops out
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
   lfsr_step = state >> 1;
   if (state[0]) begin
      lfsr_step = lfsr_step ^ glbl_map_pkg::LFSR_TAPS;
   end
endfunction

// Status image of one request pattern
// Async order is usb i2c rtc ir
// gpio 7:0 has no slot
function automatic logic [31:0] req_to_stat(input logic [3:0] async_req,
                                            input logic [2:0] timer_req,
                                            input logic pwm_req,
                                            input logic [31:0] gpio_req);
   req_to_stat = {gpio_req[31:8], async_req[3], async_req[2], pwm_req,
                  async_req[0], async_req[1], timer_req};
endfunction

function automatic logic [31:0] model_read(input glbl_map_pkg::reg_addr_t addr);
   if (addr == glbl_map_pkg::ADDR_INTR_STAT) begin
      model_read = stat_model;
   end else if (addr == glbl_map_pkg::ADDR_RANDOM) begin
      model_read = lfsr_model;
   end else begin
      model_read = shadow[addr];
   end
endfunction

// Byte-enable write with W1C on status
function automatic void model_write(input glbl_map_pkg::reg_addr_t addr,
                                    input logic [31:0] data, input logic [3:0] be);
   logic [31:0] bits;
   bits = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   case (addr)
      5'd1, 5'd2, 5'd3, 5'd5, 5'd15, 5'd16, 5'd17, 5'd18, 5'd19:
         shadow[addr] = (shadow[addr] & ~bits) | (data & bits);
      5'd4: stat_model = stat_model & ~(data & bits);
      default: ;
   endcase
endfunction

// ----------------------------------------
// Bus tasks entered just after a rising edge
// ----------------------------------------
task automatic bus_access(input logic wr, input glbl_map_pkg::reg_addr_t addr,
                          input logic [31:0] wdata, input logic [3:0] be,
                          output logic [31:0] rdata);
   reg_cs    = 1'b1;
   reg_wr    = wr;
   reg_addr  = addr;
   reg_wdata = wdata;
   reg_be    = be;
   @(posedge mclk);
   #1;
   while (!reg_ack) begin
      @(posedge mclk);
      #1;
   end
   rdata = reg_rdata;
   // Held through the ack cycle so the status clear lands
   @(posedge mclk);
   #1;
   // Ack lasts one cycle even with select still high
   check_val("reg_ack", 32'h0, {31'h0, reg_ack});
   reg_cs = 1'b0;
   reg_wr = 1'b0;
   lfsr_model = lfsr_step(lfsr_model);
   if (wr) begin
      model_write(addr, wdata, be);
   end
endtask

task automatic bus_write(input glbl_map_pkg::reg_addr_t addr, input logic [31:0] data,
                         input logic [3:0] be);
   logic [31:0] unused;
   bus_access(1'b1, addr, data, be, unused);
endtask

task automatic check_val(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
   check_count++;
   if (act_val !== exp_val) begin
      $display("FAIL %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
      error_count++;
   end
endtask

task automatic read_check(input glbl_map_pkg::reg_addr_t addr);
   logic [31:0] exp_val;
   logic [31:0] got;
   exp_val = model_read(addr);
   bus_access(1'b0, addr, 32'h0, 4'h0, got);
   check_val($sformatf("reg_rdata[%0d]", addr), exp_val, got);
endtask

`endif

// ==== tests/tb_glbl_reg.sv ====
// Global register block testbench
`timescale 1ns/1ps
`default_nettype none

module tb_glbl_reg;

   localparam int SYNC_STAGES = glbl_intr_pkg::SYNC_STAGES_DEF;
   localparam int N_WR        = 200;
   localparam int N_INTR      = 24;
   localparam int N_RAND      = 40;
   // Idle waits and resets counted as extra accesses
   localparam int ACC_TOTAL   = 32 + 2 * N_WR + 6 * N_INTR + 2 * N_RAND + 10;
   localparam int MAX_CYCLES  = 5 * ACC_TOTAL * 4;

   logic mclk = 1'b0;
   logic s_reset_n;
   logic strap_boot_run;
   logic reg_cs;
   logic reg_wr;
   glbl_map_pkg::reg_addr_t reg_addr;
   logic [31:0] reg_wdata;
   logic [3:0]  reg_be;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   logic [3:0]  async_intr;
   logic [2:0]  timer_intr;
   logic        pwm_intr;
   logic [31:0] gpio_intr;
   logic [31:0] irq_lines;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic [15:0] cfg_riscv_ctrl;
   logic [31:0] cfg_multi_func_sel;
   logic        cpu_intf_rst_n;
   logic        qspim_rst_n;
   logic        sspim_rst_n;
   logic [1:0]  uart_rst_n;
   logic        i2cm_rst_n;
   logic        usb_rst_n;
   logic [3:0]  cpu_core_rst_n;
   integer      seed = 13;
   int          error_count = 0;
   int          check_count = 0;
   int          cycle_cnt = 0;

   `include "glbl_reg_model.svh"

   glbl_reg_top #(
      .SYNC_STAGES (SYNC_STAGES)
   ) dut_i (
      .mclk (mclk), .s_reset_n (s_reset_n), .strap_boot_run (strap_boot_run),
      .reg_cs (reg_cs), .reg_wr (reg_wr), .reg_addr (reg_addr),
      .reg_wdata (reg_wdata), .reg_be (reg_be), .reg_rdata (reg_rdata),
      .reg_ack (reg_ack), .async_intr (async_intr), .timer_intr (timer_intr),
      .pwm_intr (pwm_intr), .gpio_intr (gpio_intr), .irq_lines (irq_lines),
      .soft_irq (soft_irq), .user_irq (user_irq), .cfg_riscv_ctrl (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel), .cpu_intf_rst_n (cpu_intf_rst_n),
      .qspim_rst_n (qspim_rst_n), .sspim_rst_n (sspim_rst_n),
      .uart_rst_n (uart_rst_n), .i2cm_rst_n (i2cm_rst_n), .usb_rst_n (usb_rst_n),
      .cpu_core_rst_n (cpu_core_rst_n)
   );

   // 20 ns clock
   always #10 mclk = ~mclk;

   // Watchdog
   always @(posedge mclk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("test failed");
         $finish;
      end
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic set_requests(input logic [3:0] a, input logic [2:0] t, input logic p,
                               input logic [31:0] g);
      async_intr = a;
      timer_intr = t;
      pwm_intr   = p;
      gpio_intr  = g;
   endtask

   // Reset held 8 cycles and released just after an edge
   task automatic apply_reset(input logic boot_run);
      strap_boot_run = boot_run;
      s_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = '0;
      reg_wdata      = 32'h0;
      reg_be         = 4'h0;
      set_requests(4'h0, 3'h0, 1'b0, 32'h0);
      repeat (8) @(posedge mclk);
      #1;
      s_reset_n = 1'b1;
      model_reset(boot_run);
      // Bus outputs idle out of reset
      check_val("reg_ack", 32'h0, {31'h0, reg_ack});
      check_val("reg_rdata", 32'h0, reg_rdata);
   endtask

   // Core side outputs against shadow words
   task automatic check_outputs();
      check_val("irq_lines", shadow[3] & stat_model, irq_lines);
      // Core configuration fields
      check_val("soft_irq", {31'h0, shadow[2][3]}, {31'h0, soft_irq});
      check_val("user_irq", {29'h0, shadow[2][2:0]}, {29'h0, user_irq});
      check_val("cfg_riscv_ctrl", {16'h0, shadow[2][31:16]}, {16'h0, cfg_riscv_ctrl});
      check_val("cfg_multi_func_sel", shadow[5], cfg_multi_func_sel);
      // Reset control slices
      check_val("cpu_intf_rst_n", {31'h0, shadow[1][0]}, {31'h0, cpu_intf_rst_n});
      check_val("qspim_rst_n", {31'h0, shadow[1][1]}, {31'h0, qspim_rst_n});
      check_val("sspim_rst_n", {31'h0, shadow[1][2]}, {31'h0, sspim_rst_n});
      check_val("uart_rst_n", {30'h0, shadow[1][6], shadow[1][3]}, {30'h0, uart_rst_n});
      check_val("i2cm_rst_n", {31'h0, shadow[1][4]}, {31'h0, i2cm_rst_n});
      check_val("usb_rst_n", {31'h0, shadow[1][5]}, {31'h0, usb_rst_n});
      check_val("cpu_core_rst_n", {28'h0, shadow[1][11:8]}, {28'h0, cpu_core_rst_n});
   endtask

   function automatic glbl_map_pkg::reg_addr_t writable_addr(input logic [3:0] idx);
      case (idx % 9)
         0: writable_addr = glbl_map_pkg::ADDR_RST_CTRL;
         1: writable_addr = glbl_map_pkg::ADDR_CORE_CFG;
         2: writable_addr = glbl_map_pkg::ADDR_INTR_MASK;
         3: writable_addr = glbl_map_pkg::ADDR_MFUNC_SEL;
         4: writable_addr = glbl_map_pkg::ADDR_MAILBOX;
         default: writable_addr = 5'(glbl_map_pkg::ADDR_SW0 + (idx % 9) - 5);
      endcase
   endfunction

   task automatic report_test(input string name, input int errs_before);
      if (error_count == errs_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d mismatches", name, error_count - errs_before);
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      logic [31:0] rnd;
      logic [31:0] gpio_req;
      glbl_map_pkg::reg_addr_t addr;
      int errs0;

      // Reset values
      errs0 = error_count;
      apply_reset(1'b1);
      check_outputs();
      for (int a = 0; a < 32; a++) begin
         read_check(5'(a));
      end
      report_test("reset values", errs0);

      // Byte-enable writes mostly to writable words
      errs0 = error_count;
      for (int i = 0; i < N_WR; i++) begin
         rnd  = $random(seed);
         addr = (rnd[7:6] == 2'b00) ? rnd[4:0] : writable_addr(rnd[11:8]);
         bus_write(addr, $random(seed), rnd[15:12]);
         check_outputs();
         read_check(rnd[16] ? addr : rnd[21:17]);
      end
      report_test("byte-enable writes", errs0);

      // Sticky status with W1C and masked lines
      errs0 = error_count;
      for (int i = 0; i < N_INTR; i++) begin
         rnd = $random(seed);
         bus_write(glbl_map_pkg::ADDR_INTR_MASK, $random(seed), rnd[31:28]);
         // Sparse gpio so the status does not saturate
         gpio_req = $random(seed) & $random(seed) & $random(seed);
         set_requests(rnd[3:0], rnd[6:4], rnd[7], gpio_req);
         repeat (2 + rnd[9:8]) @(posedge mclk);
         #1;
         set_requests(4'h0, 3'h0, 1'b0, 32'h0);
         repeat (SYNC_STAGES + 2) @(posedge mclk);
         #1;
         stat_model = stat_model | req_to_stat(rnd[3:0], rnd[6:4], rnd[7], gpio_req);
         check_outputs();
         read_check(glbl_map_pkg::ADDR_INTR_STAT);
         bus_write(glbl_map_pkg::ADDR_INTR_STAT, $random(seed), rnd[27:24]);
         check_outputs();
         read_check(glbl_map_pkg::ADDR_INTR_STAT);
      end
      report_test("interrupt status", errs0);

      // Random word with other accesses mixed in
      errs0 = error_count;
      for (int i = 0; i < N_RAND; i++) begin
         read_check(glbl_map_pkg::ADDR_RANDOM);
         rnd = $random(seed);
         if (rnd[0]) begin
            bus_write(glbl_map_pkg::ADDR_MAILBOX, rnd, 4'hF);
         end else if (rnd[1]) begin
            read_check(rnd[12:8]);
         end
      end
      report_test("random generator", errs0);

      // Boot strap low holds core 0
      errs0 = error_count;
      apply_reset(1'b0);
      check_outputs();
      check_val("cpu_core_rst_n[0]", 32'h0, {31'h0, cpu_core_rst_n[0]});
      read_check(glbl_map_pkg::ADDR_RST_CTRL);
      read_check(glbl_map_pkg::ADDR_INTR_MASK);
      read_check(glbl_map_pkg::ADDR_INTR_STAT);
      report_test("boot strap", errs0);

      $display("Summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tests
common/glbl_map_pkg.sv
common/glbl_intr_pkg.sv
hw/lfsr_random.sv
intr/intr_ctrl.sv
regs/glbl_reg_file.sv
hw/glbl_reg_top.sv
tests/tb_glbl_reg.sv
